/* flist.f */
fetch_pkg.sv
axi_lite_if.sv
pc_ctrl.sv
req_arbiter.sv
axi_master.sv
axi_mem_slave.sv
fetch_top.sv
tb_fetch.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_fetch
FLIST     = flist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_fetch.sv */
`timescale 1ns/1ns

module tb_fetch import fetch_pkg::*; ();

  // cycles any single wait may take, covers the slave's clear sweep
  localparam int TIMEOUT = 1000;

  logic              clk;
  logic              rst_n;
  logic              redirect_i;
  logic [XLEN-1:0]   redirect_pc_i;
  logic              stall_i;
  logic              mem_req_i;
  logic              mem_we_i;
  logic [XLEN-1:0]   mem_addr_i;
  logic [XLEN-1:0]   mem_wdata_i;
  logic [STRB_W-1:0] mem_wstrb_i;
  logic              mem_done_o;
  logic [XLEN-1:0]   mem_rdata_o;
  logic [INST_W-1:0] inst_o;
  logic [XLEN-1:0]   inst_pc_o;
  logic              inst_valid_o;

  // model of the slave memory, updated as each write is issued
  logic [XLEN-1:0]   ref_mem [MEM_WORDS];
  logic [XLEN-1:0]   exp_pc;
  logic [XLEN-1:0]   fetch_word;
  logic [INST_W-1:0] exp_inst;
  logic [XLEN-1:0]   rd_addr;
  logic [XLEN-1:0]   exp_rdata;
  logic              rd_check;
  logic              quiet;
  logic [63:0]       rng;
  int                reqs_issued = 0;
  int                dones_seen = 0;
  int                errors = 0;
  int                err_mark = 0;
  int                tests_run = 0;
  int                tests_failed = 0;

  fetch_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // next expected fetch pc, a redirect replaces it
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc <= RESET_PC;
    end else if (redirect_i) begin
      exp_pc <= redirect_pc_i;
    end else if (inst_valid_o) begin
      exp_pc <= exp_pc + XLEN'(4);
    end
  end

  always @(posedge clk) begin
    if (mem_done_o) begin
      dones_seen <= dones_seen + 1;
    end
  end

  // pc bit 2 selects the upper half
  assign fetch_word = ref_mem[exp_pc[3 +: MEM_IDX_W]];
  assign exp_inst   = exp_pc[2] ? fetch_word[INST_W +: INST_W] : fetch_word[0 +: INST_W];
  assign exp_rdata  = ref_mem[rd_addr[3 +: MEM_IDX_W]];

  a_nop_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !inst_valid_o |-> inst_o == NOP_INST)
    else begin
      errors++;
      $display("Error: inst_o = %h with no valid, expected %h", $sampled(inst_o), NOP_INST);
    end

  a_inst_pc: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_o |-> inst_pc_o == exp_pc)
    else begin
      errors++;
      $display("Error: inst_pc_o = %h, expected %h", $sampled(inst_pc_o), $sampled(exp_pc));
    end

  a_inst_value: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_o |-> inst_o == exp_inst)
    else begin
      errors++;
      $display("Error: inst_o = %h, expected %h", $sampled(inst_o), $sampled(exp_inst));
    end

  // stalled since reset, so nothing may be fetched
  a_stall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    quiet |-> !inst_valid_o)
    else begin
      errors++;
      $display("inst_valid_o pulsed although the pipeline was stalled since reset");
    end

  // one done per request, never a spare one
  a_done_once: assert property (@(posedge clk) disable iff (!rst_n)
    mem_done_o |-> dones_seen < reqs_issued)
    else begin
      errors++;
      $display("mem_done_o pulsed with no data request outstanding");
    end

  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    mem_done_o && rd_check |-> mem_rdata_o == exp_rdata)
    else begin
      errors++;
      $display("Error: mem_rdata_o = %h, expected %h", $sampled(mem_rdata_o),
               $sampled(exp_rdata));
    end

  function automatic logic [63:0] next_rand(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  // one data request, then wait for its done
  task automatic mem_access(input logic we, input logic [XLEN-1:0] addr,
                            input logic [XLEN-1:0] data, input logic [STRB_W-1:0] strb);
    logic [XLEN-1:0] merged;
    int n;
    int b;
    @(posedge clk);
    // old word with the strobed bytes replaced
    merged = ref_mem[addr[3 +: MEM_IDX_W]];
    for (b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = data[8*b +: 8];
      end
    end
    if (we) begin
      ref_mem[addr[3 +: MEM_IDX_W]] = merged;
    end
    rd_check = ~we;
    rd_addr  = addr;
    reqs_issued++;
    mem_req_i   <= 1'b1;
    mem_we_i    <= we;
    mem_addr_i  <= addr;
    mem_wdata_i <= data;
    mem_wstrb_i <= strb;
    @(posedge clk);
    mem_req_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!mem_done_o && n < TIMEOUT);
    if (!mem_done_o) begin
      errors++;
      $display("no mem_done_o arrived for the request to address %h", addr);
    end
  endtask

  task automatic wait_fetches(input int count);
    int seen;
    int n;
    seen = 0;
    n = 0;
    while (seen < count && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      if (inst_valid_o) begin
        seen++;
      end
    end
    if (seen < count) begin
      errors++;
      $display("only %0d of %0d fetch pulses arrived in time", seen, count);
    end
  endtask

  task automatic redirect_to(input logic [XLEN-1:0] target);
    @(posedge clk);
    redirect_i    <= 1'b1;
    redirect_pc_i <= target;
    @(posedge clk);
    redirect_i    <= 1'b0;
  endtask

  task automatic open_test();
    err_mark = errors;
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_mark);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  initial begin
    int i;
    rst_n         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    stall_i       = 1'b1;
    mem_req_i     = 1'b0;
    mem_we_i      = 1'b0;
    mem_addr_i    = '0;
    mem_wdata_i   = '0;
    mem_wstrb_i   = '0;
    quiet         = 1'b1;
    rd_check      = 1'b0;
    rd_addr       = '0;
    rng           = 64'd96965;
    // slave memory reads zero until written
    for (i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    open_test();
    repeat (20) @(posedge clk);
    close_test("idle after reset, stalled");

    // these words are also the instructions fetched later
    open_test();
    for (i = 0; i < 8; i++) begin
      rng = next_rand(rng);
      mem_access(1'b1, RESET_PC + XLEN'(8 * i), rng, '1);
    end
    for (i = 0; i < 8; i++) begin
      mem_access(1'b0, RESET_PC + XLEN'(8 * i), '0, '0);
    end
    close_test("full word writes and read back");

    open_test();
    rng = next_rand(rng);
    mem_access(1'b1, RESET_PC + XLEN'(24), rng, 8'h5a);
    mem_access(1'b0, RESET_PC + XLEN'(24), '0, '0);
    close_test("partial strobe write");

    open_test();
    @(posedge clk);
    stall_i <= 1'b0;
    quiet = 1'b0;
    wait_fetches(10);
    close_test("sequential fetch from reset pc");

    // the next fetch is already in flight here
    open_test();
    redirect_to(RESET_PC + XLEN'(20));
    wait_fetches(4);
    close_test("redirect drops the stale fetch");

    open_test();
    wait_fetches(2);
    mem_access(1'b0, RESET_PC + XLEN'(24), '0, '0);
    wait_fetches(6);
    close_test("data read during fetching");

    repeat (4) @(posedge clk);
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* fetch_top.sv */
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              redirect_i,
  input  logic [XLEN-1:0]   redirect_pc_i,
  input  logic              stall_i,
  input  logic              mem_req_i,
  input  logic              mem_we_i,
  input  logic [XLEN-1:0]   mem_addr_i,
  input  logic [XLEN-1:0]   mem_wdata_i,
  input  logic [STRB_W-1:0] mem_wstrb_i,
  output logic              mem_done_o,
  output logic [XLEN-1:0]   mem_rdata_o,
  output logic [INST_W-1:0] inst_o,
  output logic [XLEN-1:0]   inst_pc_o,
  output logic              inst_valid_o
);

  // fetch side to arbiter
  logic              fetch_req;
  logic [XLEN-1:0]   fetch_addr;
  logic              fetch_done;
  logic [XLEN-1:0]   fetch_data;

  // arbiter to bus master
  logic              start;
  logic [ID_W-1:0]   start_id;
  logic [XLEN-1:0]   start_addr;
  logic              start_we;
  logic [XLEN-1:0]   start_wdata;
  logic [STRB_W-1:0] start_wstrb;
  logic              done;
  logic [ID_W-1:0]   done_id;
  logic [XLEN-1:0]   rdata;

  axi_lite_if bus ();

  pc_ctrl u_pc_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .fetch_req_o   (fetch_req),
    .fetch_addr_o  (fetch_addr),
    .fetch_done_i  (fetch_done),
    .fetch_data_i  (fetch_data),
    .inst_o        (inst_o),
    .inst_pc_o     (inst_pc_o),
    .inst_valid_o  (inst_valid_o)
  );

  req_arbiter u_req_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_req_i   (fetch_req),
    .fetch_addr_i  (fetch_addr),
    .mem_req_i     (mem_req_i),
    .mem_we_i      (mem_we_i),
    .mem_addr_i    (mem_addr_i),
    .mem_wdata_i   (mem_wdata_i),
    .mem_wstrb_i   (mem_wstrb_i),
    .start_o       (start),
    .start_id_o    (start_id),
    .start_addr_o  (start_addr),
    .start_we_o    (start_we),
    .start_wdata_o (start_wdata),
    .start_wstrb_o (start_wstrb),
    .done_i        (done),
    .done_id_i     (done_id),
    .rdata_i       (rdata),
    .fetch_done_o  (fetch_done),
    .fetch_data_o  (fetch_data),
    .mem_done_o    (mem_done_o),
    .mem_rdata_o   (mem_rdata_o)
  );

  axi_master u_axi_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_i   (start),
    .id_i      (start_id),
    .addr_i    (start_addr),
    .we_i      (start_we),
    .wdata_i   (start_wdata),
    .wstrb_i   (start_wstrb),
    .done_o    (done),
    .done_id_o (done_id),
    .rdata_o   (rdata),
    .bus       (bus.master)
  );

  axi_mem_slave u_axi_mem_slave (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus.slave)
  );

endmodule

/* axi_mem_slave.sv */
`timescale 1ns/1ns

module axi_mem_slave import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  axi_lite_if.slave  bus
);

  typedef enum logic [1:0] {S_IDLE, S_WAIT, S_RESP} state_t;

  logic [XLEN-1:0]      mem [MEM_WORDS];
  state_t               state;
  logic                 clr_busy;
  logic [MEM_IDX_W-1:0] clr_idx;
  logic [LAT_W-1:0]     cnt;
  logic                 is_wr_q;
  logic [MEM_IDX_W-1:0] idx_q;
  logic [ID_W-1:0]      id_q;
  logic [XLEN-1:0]      wdata_q;
  logic [STRB_W-1:0]    wstrb_q;
  logic [XLEN-1:0]      rdata_q;
  logic                 r_valid_q;
  logic                 b_valid_q;
  logic                 idle;
  logic                 ar_fire;
  logic                 wr_fire;
  logic                 resp_go;

  // nothing accepted while the clear sweep runs
  assign idle = (state == S_IDLE) & ~clr_busy;

  // reads take priority, a write needs aw and w in the same cycle
  assign bus.ar_ready = idle;
  assign ar_fire      = bus.ar_valid & idle;
  assign wr_fire      = idle & bus.aw_valid & bus.w_valid & ~bus.ar_valid;
  assign bus.aw_ready = wr_fire;
  assign bus.w_ready  = wr_fire;

  // last wait cycle, response shows up on the next one
  assign resp_go = (state == S_WAIT) & (cnt <= LAT_W'(1));

  assign bus.r_valid = r_valid_q;
  assign bus.r_data  = rdata_q;
  assign bus.r_id    = id_q;
  assign bus.b_valid = b_valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      cnt       <= '0;
      is_wr_q   <= 1'b0;
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
      clr_busy  <= 1'b1;
      clr_idx   <= '0;
    end else begin
      // zero sweep over every word
      if (clr_busy) begin
        clr_idx <= clr_idx + 1'b1;
        if (clr_idx == MEM_IDX_W'(MEM_WORDS - 1)) begin
          clr_busy <= 1'b0;
        end
      end
      case (state)
        S_IDLE: begin
          if (ar_fire || wr_fire) begin
            is_wr_q <= wr_fire;
            cnt     <= LAT_W'(MEM_LATENCY - 1);
            state   <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (resp_go) begin
            r_valid_q <= ~is_wr_q;
            b_valid_q <= is_wr_q;
            state     <= S_RESP;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        S_RESP: begin
          if ((r_valid_q && bus.r_ready) || (b_valid_q && bus.b_ready)) begin
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // request capture, bits above the word index alias
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      idx_q <= bus.ar_addr[3 +: MEM_IDX_W];
      id_q  <= bus.ar_id;
    end else if (wr_fire) begin
      idx_q   <= bus.aw_addr[3 +: MEM_IDX_W];
      wdata_q <= bus.w_data;
      wstrb_q <= bus.w_strb;
    end
    if (resp_go && !is_wr_q) begin
      rdata_q <= mem[idx_q];
    end
  end

  // storage, cleared by the sweep then written byte by byte
  always_ff @(posedge clk) begin
    if (clr_busy) begin
      mem[clr_idx] <= '0;
    end else if (resp_go && is_wr_q) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_q[b]) begin
          mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
        end
      end
    end
  end

endmodule

/* axi_master.sv */
`timescale 1ns/1ns

module axi_master import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  logic [ID_W-1:0]   id_i,
  input  logic [XLEN-1:0]   addr_i,
  input  logic              we_i,
  input  logic [XLEN-1:0]   wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  output logic              done_o,
  output logic [ID_W-1:0]   done_id_o,
  output logic [XLEN-1:0]   rdata_o,
  axi_lite_if.master        bus
);

  typedef enum logic [2:0] {S_IDLE, S_AR, S_R, S_WR, S_B} state_t;

  state_t            state;
  logic [ID_W-1:0]   id_q;
  logic [XLEN-1:0]   addr_q;
  logic [XLEN-1:0]   wdata_q;
  logic [STRB_W-1:0] wstrb_q;
  logic              ar_valid_q;
  logic              aw_valid_q;
  logic              w_valid_q;
  logic              done_q;
  logic [ID_W-1:0]   done_id_q;
  logic [XLEN-1:0]   rdata_q;
  logic              r_fire;
  logic              b_fire;
  logic              aw_left;
  logic              w_left;

  // channel fields come straight from the captured request
  assign bus.ar_valid = ar_valid_q;
  assign bus.ar_addr  = addr_q;
  assign bus.ar_id    = id_q;
  assign bus.r_ready  = (state == S_R);
  assign bus.aw_valid = aw_valid_q;
  assign bus.aw_addr  = addr_q;
  assign bus.w_valid  = w_valid_q;
  assign bus.w_data   = wdata_q;
  assign bus.w_strb   = wstrb_q;
  assign bus.b_ready  = (state == S_B);

  assign r_fire = bus.r_valid & bus.r_ready;
  assign b_fire = bus.b_valid & bus.b_ready;

  // write channels still owed after this cycle
  assign aw_left = aw_valid_q & ~bus.aw_ready;
  assign w_left  = w_valid_q & ~bus.w_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      ar_valid_q <= 1'b0;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start_i && we_i) begin
            // aw and w go out together
            aw_valid_q <= 1'b1;
            w_valid_q  <= 1'b1;
            state      <= S_WR;
          end else if (start_i) begin
            ar_valid_q <= 1'b1;
            state      <= S_AR;
          end
        end
        S_AR: begin
          if (bus.ar_ready) begin
            ar_valid_q <= 1'b0;
            state      <= S_R;
          end
        end
        S_R: begin
          if (r_fire) begin
            done_q <= 1'b1;
            state  <= S_IDLE;
          end
        end
        S_WR: begin
          // each valid drops on its own handshake
          aw_valid_q <= aw_left;
          w_valid_q  <= w_left;
          if (!aw_left && !w_left) begin
            state <= S_B;
          end
        end
        S_B: begin
          if (b_fire) begin
            done_q <= 1'b1;
            state  <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_i && state == S_IDLE) begin
      id_q    <= id_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    // reads return the slave's id, writes the stored one
    if (r_fire) begin
      rdata_q   <= bus.r_data;
      done_id_q <= bus.r_id;
    end else if (b_fire) begin
      done_id_q <= id_q;
    end
  end

  assign done_o    = done_q;
  assign done_id_o = done_id_q;
  assign rdata_o   = rdata_q;

  // read address stays up and steady until the slave takes it
  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bus.ar_valid && !bus.ar_ready |=> bus.ar_valid && $stable(bus.ar_addr));

endmodule

/* req_arbiter.sv */
`timescale 1ns/1ns

module req_arbiter import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              fetch_req_i,
  input  logic [XLEN-1:0]   fetch_addr_i,
  input  logic              mem_req_i,
  input  logic              mem_we_i,
  input  logic [XLEN-1:0]   mem_addr_i,
  input  logic [XLEN-1:0]   mem_wdata_i,
  input  logic [STRB_W-1:0] mem_wstrb_i,
  output logic              start_o,
  output logic [ID_W-1:0]   start_id_o,
  output logic [XLEN-1:0]   start_addr_o,
  output logic              start_we_o,
  output logic [XLEN-1:0]   start_wdata_o,
  output logic [STRB_W-1:0] start_wstrb_o,
  input  logic              done_i,
  input  logic [ID_W-1:0]   done_id_i,
  input  logic [XLEN-1:0]   rdata_i,
  output logic              fetch_done_o,
  output logic [XLEN-1:0]   fetch_data_o,
  output logic              mem_done_o,
  output logic [XLEN-1:0]   mem_rdata_o
);

  logic              data_pend;
  logic              data_we;
  logic [XLEN-1:0]   data_addr;
  logic [XLEN-1:0]   data_wdata;
  logic [STRB_W-1:0] data_wstrb;
  logic              fetch_pend;
  logic [XLEN-1:0]   fetch_addr;
  logic              busy;
  logic [ID_W-1:0]   owner_id;
  logic              sel_data;
  logic              fin;

  // data always beats a waiting fetch
  assign sel_data = data_pend;
  assign start_o  = ~busy & (data_pend | fetch_pend);

  assign start_id_o    = sel_data ? ID_DATA : ID_FETCH;
  assign start_addr_o  = sel_data ? data_addr : fetch_addr;
  assign start_we_o    = sel_data & data_we;
  assign start_wdata_o = data_wdata;
  assign start_wstrb_o = data_wstrb;

  // bus is free again once the owner's transaction returns
  assign fin = done_i & (done_id_i == owner_id);

  // route completion by the id that came back
  assign fetch_done_o = done_i & (done_id_i == ID_FETCH);
  assign mem_done_o   = done_i & (done_id_i == ID_DATA);
  assign fetch_data_o = rdata_i;
  assign mem_rdata_o  = rdata_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_pend  <= 1'b0;
      fetch_pend <= 1'b0;
      busy       <= 1'b0;
      owner_id   <= '0;
    end else begin
      // request strobes are remembered until granted
      if (mem_req_i) begin
        data_pend <= 1'b1;
      end else if (start_o && sel_data) begin
        data_pend <= 1'b0;
      end

      if (fetch_req_i) begin
        fetch_pend <= 1'b1;
      end else if (start_o && !sel_data) begin
        fetch_pend <= 1'b0;
      end

      if (start_o) begin
        busy     <= 1'b1;
        owner_id <= start_id_o;
      end else if (fin) begin
        busy <= 1'b0;
      end
    end
  end

  // request fields, captured with the strobe
  always_ff @(posedge clk) begin
    if (mem_req_i) begin
      data_we    <= mem_we_i;
      data_addr  <= mem_addr_i;
      data_wdata <= mem_wdata_i;
      data_wstrb <= mem_wstrb_i;
    end
    if (fetch_req_i) begin
      fetch_addr <= fetch_addr_i;
    end
  end

  // a done from the master lands only while busy, and on exactly one side
  a_done_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> busy && (fetch_done_o != mem_done_o));

endmodule

/* pc_ctrl.sv */
`timescale 1ns/1ns

module pc_ctrl import fetch_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              redirect_i,
  input  logic [XLEN-1:0]   redirect_pc_i,
  input  logic              stall_i,
  output logic              fetch_req_o,
  output logic [XLEN-1:0]   fetch_addr_o,
  input  logic              fetch_done_i,
  input  logic [XLEN-1:0]   fetch_data_i,
  output logic [INST_W-1:0] inst_o,
  output logic [XLEN-1:0]   inst_pc_o,
  output logic              inst_valid_o
);

  logic [XLEN-1:0]   pc;
  logic              in_flight;
  logic              stale;
  logic              keep;
  logic              inst_valid_q;
  logic [INST_W-1:0] inst_q;
  logic [XLEN-1:0]   inst_pc_q;

  // one fetch outstanding at most, none while stalled
  assign fetch_req_o  = ~in_flight & ~stall_i;
  // a redirect in the request cycle steers the request itself
  assign fetch_addr_o = redirect_i ? redirect_pc_i : pc;

  // completion counts only if no redirect overtook it
  assign keep = fetch_done_i & ~stale & ~redirect_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc           <= RESET_PC;
      in_flight    <= 1'b0;
      stale        <= 1'b0;
      inst_valid_q <= 1'b0;
    end else begin
      // redirect replaces the pc, else step past a good fetch
      if (redirect_i) begin
        pc <= redirect_pc_i;
      end else if (keep) begin
        pc <= pc + XLEN'(4);
      end

      if (fetch_req_o) begin
        in_flight <= 1'b1;
      end else if (fetch_done_i) begin
        in_flight <= 1'b0;
      end

      // stale marks a fetch whose address is no longer wanted
      if (fetch_done_i) begin
        stale <= 1'b0;
      end else if (redirect_i && in_flight) begin
        stale <= 1'b1;
      end

      // valid pulse one cycle after the bus done
      inst_valid_q <= keep;
    end
  end

  // pc still names the completing fetch when keep is set
  always_ff @(posedge clk) begin
    if (keep) begin
      // pc bit 2 picks the upper or lower half of the word
      inst_q    <= pc[2] ? fetch_data_i[INST_W +: INST_W] : fetch_data_i[0 +: INST_W];
      inst_pc_q <= pc;
    end
  end

  // nop whenever nothing valid is on the output
  assign inst_o       = inst_valid_q ? inst_q : NOP_INST;
  assign inst_pc_o    = inst_pc_q;
  assign inst_valid_o = inst_valid_q;

  // arbiter only reports a fetch done for our outstanding request
  a_done_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_done_i |-> in_flight);

endmodule

/* axi_lite_if.sv */
`timescale 1ns/1ns

interface axi_lite_if import fetch_pkg::*; ();

  // read address
  logic              ar_valid;
  logic              ar_ready;
  logic [XLEN-1:0]   ar_addr;
  logic [ID_W-1:0]   ar_id;

  // read data
  logic              r_valid;
  logic              r_ready;
  logic [XLEN-1:0]   r_data;
  logic [ID_W-1:0]   r_id;

  // write address
  logic              aw_valid;
  logic              aw_ready;
  logic [XLEN-1:0]   aw_addr;

  // write data
  logic              w_valid;
  logic              w_ready;
  logic [XLEN-1:0]   w_data;
  logic [STRB_W-1:0] w_strb;

  // write response
  logic              b_valid;
  logic              b_ready;

  modport master (
    output ar_valid, ar_addr, ar_id, r_ready,
    output aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
    input  ar_ready, r_valid, r_data, r_id, aw_ready, w_ready, b_valid
  );

  modport slave (
    input  ar_valid, ar_addr, ar_id, r_ready,
    input  aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
    output ar_ready, r_valid, r_data, r_id, aw_ready, w_ready, b_valid
  );

endinterface

/* fetch_pkg.sv */
package fetch_pkg;

  // datapath widths
  localparam int XLEN   = 64;
  localparam int INST_W = 32;
  localparam int STRB_W = XLEN / 8;

  // transaction ids carried on the bus
  localparam int ID_W = 4;
  localparam logic [ID_W-1:0] ID_FETCH = 4'd1;
  localparam logic [ID_W-1:0] ID_DATA  = 4'd2;

  // first fetch address out of reset
  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

  // addi x0,x0,0
  localparam logic [INST_W-1:0] NOP_INST = 32'h0000_0013;

  // on-chip memory, 64-bit words
  localparam int MEM_WORDS = 256;
  // word index width, taken from address bit 3 upward
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  // cycles from address accept to response valid
  localparam int MEM_LATENCY = 2;
  // width of the slave's latency counter
  localparam int LAT_W = $clog2(MEM_LATENCY + 1);

endpackage
